/* Bender.yml */
package:
  name: mouse_soc

sources:
  - hdl/mouse_pkg.sv
  - hdl/tcb_if.sv
  - hdl/mouse_core.sv
  - hdl/tcb_ram.sv
  - hdl/tcb_trace.sv
  - hdl/mouse_soc.sv
  - target: test
    files:
      - test/mouse_tb.sv

/* files.f */
hdl/mouse_pkg.sv
hdl/tcb_if.sv
hdl/mouse_core.sv
hdl/tcb_ram.sv
hdl/tcb_trace.sv
hdl/mouse_soc.sv
test/mouse_tb.sv

/* hdl/mouse_core.sv */
/*
  phase-sequenced RV32I subset core
  GPRs live in a RAM window, every step of an instruction is one bus transfer
*/

module mouse_core #(
  parameter logic [mouse_pkg::adr_w-1:0] GPR_BASE = 32'h0000_0f80,
  parameter logic [mouse_pkg::adr_w-1:0] RESET_PC = 32'h0000_0000
) (
  input  logic bus,
  input  logic reset,
  tcb_if.man   tcb
);
  import mouse_pkg::*;

  ////////////////////////////////////////
  // local signals

  // control state
  phase_t pha;
  phase_t nxt_pha;
  logic   boot;
  logic   vld;
  logic   rsp;
  logic   stp;

  // program counter
  logic [adr_w-1:0] pc;
  logic [adr_w-1:0] nxt_pc;
  logic             taken;

  // instruction and operands
  logic [dat_w-1:0] ins;
  logic [dat_w-1:0] cur_ins;
  inst_t            dec;
  logic [dat_w-1:0] rs1_dat;
  logic [dat_w-1:0] rs2_dat;
  logic [dat_w-1:0] op_a;
  logic [dat_w-1:0] op_b;
  logic [dat_w-1:0] wb_dat;

  // next request
  logic [adr_w-1:0] req_adr;
  logic             req_wen;
  logic [ben_w-1:0] req_ben;
  logic [dat_w-1:0] req_wdt;

  // byte address of a GPR word in the window
  function automatic logic [adr_w-1:0] gpr_adr(gpr_idx_t idx);
    return GPR_BASE + adr_w'({idx, 2'b00});
  endfunction

  // add/sub and logic ops, selected by funct3
  function automatic logic [dat_w-1:0] alu(
    logic [2:0]       f3,
    logic             sub,
    logic [dat_w-1:0] a,
    logic [dat_w-1:0] b
  );
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return '0;
    endcase
  endfunction

  ////////////////////////////////////////
  // decode and datapath

  // on a fetch response decode straight from the bus
  assign cur_ins = (rsp && pha == ph_if) ? tcb.rdt : ins;
  assign dec     = decode(cur_ins);

  // operands bypass the response of the phase that reads them
  assign op_a = (rsp && pha == ph_rs1) ? tcb.rdt : rs1_dat;
  assign op_b = (rsp && pha == ph_rs2) ? tcb.rdt : rs2_dat;

  // step when a response arrives, in exe, or right after reset
  assign stp = boot || rsp || (pha == ph_exe);

  // branch condition, funct3 bit 0 flips BEQ into BNE
  assign taken = (dec.opcode == op_jal) ||
                 (dec.opcode == op_branch && ((rs1_dat == rs2_dat) ^ dec.funct3[0]));

  always_comb begin
    if (nxt_pha == ph_if && !boot) begin
      nxt_pc = taken ? pc + dec.imm : pc + adr_w'(4);
    end else begin
      nxt_pc = pc;
    end
  end

  // write-back value by opcode
  always_comb begin
    case (dec.opcode)
      op_lui:  wb_dat = dec.imm;
      op_imm:  wb_dat = alu(dec.funct3, 1'b0, op_a, dec.imm);
      op_reg:  wb_dat = alu(dec.funct3, dec.funct7[5], op_a, op_b);
      op_load: wb_dat = tcb.rdt;
      // link address
      op_jal:  wb_dat = pc + 32'd4;
      default: wb_dat = '0;
    endcase
  end

  ////////////////////////////////////////
  // phase sequencing

  always_comb begin
    nxt_pha = pha;
    if (boot) begin
      nxt_pha = ph_if;
    end else if (rsp && tcb.err) begin
      // bus error stops the core for good
      nxt_pha = ph_halt;
    end else if (rsp) begin
      case (pha)
        ph_if: begin
          case (dec.opcode)
            op_lui, op_jal:                                nxt_pha = ph_wb;
            op_imm, op_load, op_reg, op_store, op_branch:  nxt_pha = ph_rs1;
            // unsupported opcode
            default:                                       nxt_pha = ph_halt;
          endcase
        end
        ph_rs1: begin
          case (dec.opcode)
            op_imm:  nxt_pha = ph_wb;
            op_load: nxt_pha = ph_mld;
            default: nxt_pha = ph_rs2;
          endcase
        end
        ph_rs2: begin
          case (dec.opcode)
            op_reg:   nxt_pha = ph_wb;
            op_store: nxt_pha = ph_mst;
            default:  nxt_pha = ph_exe;
          endcase
        end
        ph_mld:  nxt_pha = ph_wb;
        // store and write-back end the instruction
        default: nxt_pha = ph_if;
      endcase
    end else if (pha == ph_exe) begin
      nxt_pha = ph_if;
    end
  end

  // request for the phase about to start
  always_comb begin
    req_wen = (nxt_pha == ph_mst) || (nxt_pha == ph_wb);
    // x0 write-back goes out with no byte enabled
    req_ben = (nxt_pha == ph_wb && dec.rd == '0) ? '0 : '1;
    req_wdt = '0;
    case (nxt_pha)
      ph_rs1:         req_adr = gpr_adr(dec.rs1);
      ph_rs2:         req_adr = gpr_adr(dec.rs2);
      ph_mld, ph_mst: req_adr = op_a + dec.imm;
      ph_wb:          req_adr = gpr_adr(dec.rd);
      default:        req_adr = nxt_pc;
    endcase
    if (nxt_pha == ph_mst) begin
      req_wdt = op_b;
    end else if (nxt_pha == ph_wb) begin
      req_wdt = wb_dat;
    end
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      boot <= 1'b1;
      pha  <= ph_if;
      vld  <= 1'b0;
      rsp  <= 1'b0;
      pc   <= RESET_PC;
    end else begin
      boot <= 1'b0;
      rsp  <= vld;
      vld  <= 1'b0;
      if (stp) begin
        pha <= nxt_pha;
        pc  <= nxt_pc;
        // exe and halt issue no transfer
        vld <= (nxt_pha != ph_exe) && (nxt_pha != ph_halt);
      end
    end
  end

  // request payload and captured responses
  always_ff @(posedge bus) begin
    if (stp) begin
      tcb.adr <= req_adr;
      tcb.wen <= req_wen;
      tcb.ben <= req_ben;
      tcb.wdt <= req_wdt;
    end
    if (rsp) begin
      case (pha)
        ph_if:   ins     <= tcb.rdt;
        ph_rs1:  rs1_dat <= tcb.rdt;
        ph_rs2:  rs2_dat <= tcb.rdt;
        default: ;
      endcase
    end
  end

  assign tcb.vld = vld;
  assign tcb.pha = pha;

  ////////////////////////////////////////
  // checks

  // every transfer is followed by its response cycle
  a_vld_gap: assert property (@(posedge bus) disable iff (reset)
    tcb.vld |=> !tcb.vld);

  // memory must never see a real write to x0
  a_x0_wb: assert property (@(posedge bus) disable iff (reset)
    (tcb.vld && tcb.pha == ph_wb && tcb.adr == GPR_BASE) |-> (tcb.ben == '0));

endmodule

/* hdl/mouse_pkg.sv */
/*
  shared definitions for the mouse subsystem
  bus widths, phase and opcode enums, decoded instruction struct and decoder
*/

package mouse_pkg;

  // bus widths
  localparam int unsigned adr_w = 32;
  localparam int unsigned dat_w = 32;
  localparam int unsigned ben_w = dat_w / 8;

  // execution phase, tagged on every bus transfer
  // GPR access phases share bit 2 with write-back
  typedef enum logic [2:0] {
    ph_if   = 3'b000,
    ph_mld  = 3'b001,
    ph_mst  = 3'b010,
    ph_exe  = 3'b011,
    ph_wb   = 3'b100,
    ph_rs1  = 3'b101,
    ph_rs2  = 3'b110,
    ph_halt = 3'b111
  } phase_t;

  // RV32I major opcodes in the supported subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_t;

  typedef logic [4:0] gpr_idx_t;

  // decoded instruction fields
  typedef struct packed {
    opcode_t          opcode;
    gpr_idx_t         rd;
    logic [2:0]       funct3;
    gpr_idx_t         rs1;
    gpr_idx_t         rs2;
    logic [6:0]       funct7;
    logic [dat_w-1:0] imm;
  } inst_t;

  // field split and sign-extended immediate by format
  function automatic inst_t decode(logic [dat_w-1:0] ins);
    inst_t dec;
    dec.opcode = opcode_t'(ins[6:0]);
    dec.rd     = ins[11:7];
    dec.funct3 = ins[14:12];
    dec.rs1    = ins[19:15];
    dec.rs2    = ins[24:20];
    dec.funct7 = ins[31:25];
    case (dec.opcode)
      // U-type
      op_lui:    dec.imm = {ins[31:12], 12'h000};
      // S-type
      op_store:  dec.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      // B-type, bit 0 always zero
      op_branch: dec.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      // J-type
      op_jal:    dec.imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      // I-type for imm and load
      default:   dec.imm = {{20{ins[31]}}, ins[31:20]};
    endcase
    return dec;
  endfunction

endpackage

/* hdl/mouse_soc.sv */
/*
  subsystem top level
  core, RAM and tracer on one bus, program load and retirement ports
*/

module mouse_soc #(
  parameter int unsigned                 MEM_WORDS = 1024,
  parameter logic [mouse_pkg::adr_w-1:0] GPR_BASE  = 32'h0000_0f80,
  parameter logic [mouse_pkg::adr_w-1:0] RESET_PC  = 32'h0000_0000
) (
  input  logic                        bus,
  input  logic                        reset,
  // program load, during reset only
  input  logic                        load_en,
  input  logic [mouse_pkg::adr_w-1:0] load_adr,
  input  logic [mouse_pkg::dat_w-1:0] load_dat,
  // retirement records
  output logic                        ret_vld,
  output logic [mouse_pkg::adr_w-1:0] ret_pc,
  output logic [mouse_pkg::dat_w-1:0] ret_ins,
  output logic                        ret_rd_we,
  output mouse_pkg::gpr_idx_t         ret_rd,
  output logic [mouse_pkg::dat_w-1:0] ret_rd_dat,
  output logic                        ret_mem_vld,
  output logic                        ret_mem_wen,
  output logic [mouse_pkg::adr_w-1:0] ret_mem_adr,
  output logic [mouse_pkg::dat_w-1:0] ret_mem_dat,
  output logic                        halted
);
  import mouse_pkg::*;

  tcb_if tcb ();

  // core stays in the halt phase after a bus error
  assign halted = (tcb.pha == ph_halt);

  mouse_core #(
    .GPR_BASE (GPR_BASE),
    .RESET_PC (RESET_PC)
  ) i_core (
    .bus   (bus),
    .reset (reset),
    .tcb   (tcb.man)
  );

  tcb_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) i_ram (
    .bus      (bus),
    .reset    (reset),
    .tcb      (tcb.sub),
    .load_en  (load_en),
    .load_adr (load_adr),
    .load_dat (load_dat)
  );

  tcb_trace i_trace (
    .bus         (bus),
    .reset       (reset),
    .tcb         (tcb.mon),
    .ret_vld     (ret_vld),
    .ret_pc      (ret_pc),
    .ret_ins     (ret_ins),
    .ret_rd_we   (ret_rd_we),
    .ret_rd      (ret_rd),
    .ret_rd_dat  (ret_rd_dat),
    .ret_mem_vld (ret_mem_vld),
    .ret_mem_wen (ret_mem_wen),
    .ret_mem_adr (ret_mem_adr),
    .ret_mem_dat (ret_mem_dat)
  );

endmodule

/* hdl/tcb_if.sv */
/*
  tightly coupled bus interface
  request, response and phase tag with manager, subordinate and monitor views
*/

interface tcb_if;
  import mouse_pkg::*;

  ////////////////////////////////////////
  // request, from manager
  logic             vld;
  logic             wen;
  logic [adr_w-1:0] adr;
  logic [ben_w-1:0] ben;
  logic [dat_w-1:0] wdt;
  // phase tag of the current transfer
  phase_t           pha;

  ////////////////////////////////////////
  // response, one cycle after the transfer
  logic [dat_w-1:0] rdt;
  logic             err;

  // core side
  modport man (output vld, wen, adr, ben, wdt, pha, input rdt, err);

  // memory side, phase is not decoded there
  modport sub (input vld, wen, adr, ben, wdt, output rdt, err);

  // tracer, observes everything
  modport mon (input vld, wen, adr, ben, wdt, pha, rdt, err);

endinterface

/* hdl/tcb_ram.sv */
/*
  single-port word RAM on the bus
  byte write enables, one-cycle read response, range error, program load port
*/

module tcb_ram #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic                        bus,
  input  logic                        reset,
  tcb_if.sub                          tcb,
  input  logic                        load_en,
  input  logic [mouse_pkg::adr_w-1:0] load_adr,
  input  logic [mouse_pkg::dat_w-1:0] load_dat
);
  import mouse_pkg::*;

  // index width, at least one bit
  localparam int unsigned idx_w = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [dat_w-1:0] mem [MEM_WORDS];

  // word addresses
  logic [adr_w-3:0] wrd;
  logic [adr_w-3:0] load_wrd;
  logic             in_rng;
  logic             load_rng;

  assign wrd      = tcb.adr[adr_w-1:2];
  assign load_wrd = load_adr[adr_w-1:2];
  assign in_rng   = (wrd < MEM_WORDS);
  assign load_rng = (load_wrd < MEM_WORDS);

  // writes, load port only during reset
  always_ff @(posedge bus) begin
    if (reset) begin
      if (load_en && load_rng) begin
        mem[load_wrd[idx_w-1:0]] <= load_dat;
      end
    end else if (tcb.vld && tcb.wen && in_rng) begin
      for (int b = 0; b < ben_w; b++) begin
        if (tcb.ben[b]) begin
          mem[wrd[idx_w-1:0]][8*b +: 8] <= tcb.wdt[8*b +: 8];
        end
      end
    end
  end

  // registered read data, meaningless on writes
  always_ff @(posedge bus) begin
    if (tcb.vld) begin
      tcb.rdt <= mem[wrd[idx_w-1:0]];
    end
  end

  // out of range flag for reads and dropped writes
  always_ff @(posedge bus) begin
    if (reset) begin
      tcb.err <= 1'b0;
    end else begin
      tcb.err <= tcb.vld && !in_rng;
    end
  end

  // program loading belongs to the reset window
  a_load_rst: assert property (@(posedge bus) load_en |-> reset);

endmodule

/* hdl/tcb_trace.sv */
/*
  bus tracer
  delays transfers one cycle, collects them per phase, emits retirement records
*/

module tcb_trace (
  input  logic                        bus,
  input  logic                        reset,
  tcb_if.mon                          tcb,
  output logic                        ret_vld,
  output logic [mouse_pkg::adr_w-1:0] ret_pc,
  output logic [mouse_pkg::dat_w-1:0] ret_ins,
  output logic                        ret_rd_we,
  output mouse_pkg::gpr_idx_t         ret_rd,
  output logic [mouse_pkg::dat_w-1:0] ret_rd_dat,
  output logic                        ret_mem_vld,
  output logic                        ret_mem_wen,
  output logic [mouse_pkg::adr_w-1:0] ret_mem_adr,
  output logic [mouse_pkg::dat_w-1:0] ret_mem_dat
);
  import mouse_pkg::*;

  ////////////////////////////////////////
  // bus delayed by one cycle
  logic             dly_vld;
  logic [adr_w-1:0] dly_adr;
  logic [ben_w-1:0] dly_ben;
  logic [dat_w-1:0] dly_wdt;
  phase_t           dly_pha;

  // per-instruction slots
  logic             started;
  logic [adr_w-1:0] if_adr;
  logic [dat_w-1:0] if_ins;
  logic             wb_we;
  gpr_idx_t         wb_rd;
  logic [dat_w-1:0] wb_dat;
  logic             mem_vld;
  logic             mem_wen;
  logic [adr_w-1:0] mem_adr;
  logic [dat_w-1:0] mem_dat;

  always_ff @(posedge bus) begin
    if (reset) begin
      dly_vld <= 1'b0;
    end else begin
      dly_vld <= tcb.vld;
    end
    dly_adr <= tcb.adr;
    dly_ben <= tcb.ben;
    dly_wdt <= tcb.wdt;
    dly_pha <= tcb.pha;
  end

  ////////////////////////////////////////
  // slot collection, rdt is valid with the delayed request
  always_ff @(posedge bus) begin
    if (reset) begin
      started <= 1'b0;
      ret_vld <= 1'b0;
      wb_we   <= 1'b0;
      mem_vld <= 1'b0;
    end else begin
      ret_vld <= 1'b0;
      if (dly_vld) begin
        case (dly_pha)
          ph_if: begin
            // next fetch retires the previous instruction
            if (started) begin
              ret_vld     <= 1'b1;
              ret_pc      <= if_adr;
              ret_ins     <= if_ins;
              ret_rd_we   <= wb_we;
              ret_rd      <= wb_rd;
              ret_rd_dat  <= wb_dat;
              ret_mem_vld <= mem_vld;
              ret_mem_wen <= mem_wen;
              ret_mem_adr <= mem_adr;
              ret_mem_dat <= mem_dat;
            end
            started <= 1'b1;
            if_adr  <= dly_adr;
            if_ins  <= tcb.rdt;
            wb_we   <= 1'b0;
            mem_vld <= 1'b0;
          end
          ph_wb: begin
            // zero ben marks the suppressed x0 write
            wb_we  <= &dly_ben;
            wb_rd  <= dly_adr[6:2];
            wb_dat <= dly_wdt;
          end
          ph_mld: begin
            mem_vld <= 1'b1;
            mem_wen <= 1'b0;
            mem_adr <= dly_adr;
            mem_dat <= tcb.rdt;
          end
          ph_mst: begin
            mem_vld <= 1'b1;
            mem_wen <= 1'b1;
            mem_adr <= dly_adr;
            mem_dat <= dly_wdt;
          end
          // rs1, rs2 and exe are not logged
          default: ;
        endcase
      end
    end
  end

  // partial write-back enables would make the record ambiguous
  a_wb_ben: assert property (@(posedge bus) disable iff (reset)
    (tcb.vld && tcb.pha == ph_wb) |-> (&tcb.ben || tcb.ben == '0));

endmodule

/* test/mouse_tb.sv */
/*
  directed testbench for the mouse subsystem
  reference ISA model, program loader, retirement checks
*/

module mouse_tb;

  localparam int unsigned mem_words = 1024;
  localparam logic [31:0] gpr_base  = 32'h0000_0f80;
  localparam logic [31:0] reset_pc  = 32'h0000_0000;
  localparam int          ret_limit = 60;

  // DUT ports
  logic        bus;
  logic        reset;
  logic        load_en;
  logic [31:0] load_adr;
  logic [31:0] load_dat;
  logic        ret_vld;
  logic [31:0] ret_pc;
  logic [31:0] ret_ins;
  logic        ret_rd_we;
  logic [4:0]  ret_rd;
  logic [31:0] ret_rd_dat;
  logic        ret_mem_vld;
  logic        ret_mem_wen;
  logic [31:0] ret_mem_adr;
  logic [31:0] ret_mem_dat;
  logic        halted;

  // model state
  logic [31:0] m_pc;
  logic [31:0] m_reg [32];
  logic [31:0] m_mem [int];
  logic [31:0] prog [$];

  // expected record
  logic [31:0] e_pc;
  logic [31:0] e_ins;
  logic        e_we;
  logic [4:0]  e_rd;
  logic [31:0] e_dat;
  logic        e_mvld;
  logic        e_mwen;
  logic [31:0] e_madr;
  logic [31:0] e_mdat;

  int n_checks;
  int n_errors;

  mouse_soc #(
    .MEM_WORDS (mem_words),
    .GPR_BASE  (gpr_base),
    .RESET_PC  (reset_pc)
  ) i_dut (
    .bus         (bus),
    .reset       (reset),
    .load_en     (load_en),
    .load_adr    (load_adr),
    .load_dat    (load_dat),
    .ret_vld     (ret_vld),
    .ret_pc      (ret_pc),
    .ret_ins     (ret_ins),
    .ret_rd_we   (ret_rd_we),
    .ret_rd      (ret_rd),
    .ret_rd_dat  (ret_rd_dat),
    .ret_mem_vld (ret_mem_vld),
    .ret_mem_wen (ret_mem_wen),
    .ret_mem_adr (ret_mem_adr),
    .ret_mem_dat (ret_mem_dat),
    .halted      (halted)
  );

  always #5 bus = ~bus;

  ////////////////////////////////////////
  // instruction encoders
  function automatic logic [31:0] u_format(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  // opc selects addi or lw
  function automatic logic [31:0] i_format(logic [6:0] opc, logic [4:0] rd,
                                           logic [4:0] rs1, logic [11:0] imm);
    logic [2:0] f3;
    f3 = (opc == 7'b0000011) ? 3'b010 : 3'b000;
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] r_format(logic [2:0] f3, logic sub, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
    return {1'b0, sub, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] s_format(logic [4:0] rs2, logic [4:0] rs1,
                                           logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // f3 0 for beq, 1 for bne
  function automatic logic [31:0] b_format(logic [2:0] f3, logic [4:0] rs1,
                                           logic [4:0] rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_format(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  ////////////////////////////////////////
  // reference ISA model stepping one instruction per call
  task automatic model_step();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] nxt;
    ins   = m_mem[int'(m_pc[31:2])];
    a     = m_reg[ins[19:15]];
    b     = m_reg[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    nxt   = m_pc + 32'd4;
    e_pc   = m_pc;
    e_ins  = ins;
    e_rd   = ins[11:7];
    e_we   = 1'b1;
    e_dat  = '0;
    e_mvld = 1'b0;
    e_mwen = 1'b0;
    e_madr = '0;
    e_mdat = '0;
    case (ins[6:0])
      7'b0110111: e_dat = {ins[31:12], 12'h000};
      7'b0010011: e_dat = a + imm_i;
      7'b0110011: begin
        case (ins[14:12])
          3'b000:  e_dat = ins[30] ? a - b : a + b;
          3'b100:  e_dat = a ^ b;
          3'b110:  e_dat = a | b;
          default: e_dat = a & b;
        endcase
      end
      7'b0000011: begin
        e_mvld = 1'b1;
        e_madr = a + imm_i;
        e_mdat = m_mem[int'(e_madr[31:2])];
        e_dat  = e_mdat;
      end
      7'b0100011: begin
        e_we   = 1'b0;
        e_mvld = 1'b1;
        e_mwen = 1'b1;
        e_madr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        e_mdat = b;
        m_mem[int'(e_madr[31:2])] = b;
      end
      7'b1100011: begin
        e_we = 1'b0;
        // beq taken on equal, bne on not equal
        if ((a == b) != ins[12]) begin
          nxt = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      default: begin
        // jal
        e_dat = m_pc + 32'd4;
        nxt   = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
    endcase
    // x0 stays zero and is not reported
    if (e_rd == 5'd0) begin
      e_we = 1'b0;
    end
    if (e_we) begin
      m_reg[e_rd] = e_dat;
    end
    m_pc = nxt;
  endtask

  ////////////////////////////////////////
  // checking and waiting
  task automatic check(input string tst, input string what,
                       input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("[ERROR] %s: %s expected %h actual %h", tst, what, exp, act);
    end
  endtask

  task automatic compare_record(input string tst);
    check(tst, "ret_pc", e_pc, ret_pc);
    check(tst, "ret_ins", e_ins, ret_ins);
    check(tst, "ret_rd_we", 32'(e_we), 32'(ret_rd_we));
    if (e_we) begin
      check(tst, "ret_rd", 32'(e_rd), 32'(ret_rd));
      check(tst, "ret_rd_dat", e_dat, ret_rd_dat);
    end
    check(tst, "ret_mem_vld", 32'(e_mvld), 32'(ret_mem_vld));
    if (e_mvld) begin
      check(tst, "ret_mem_wen", 32'(e_mwen), 32'(ret_mem_wen));
      check(tst, "ret_mem_adr", e_madr, ret_mem_adr);
      check(tst, "ret_mem_dat", e_mdat, ret_mem_dat);
    end
  endtask

  // waits for one ret_vld pulse sampled mid-cycle
  task automatic wait_retire(input string tst, output bit ok);
    ok = 1'b0;
    for (int n = 0; n < ret_limit && !ok; n++) begin
      @(negedge bus);
      if (ret_vld) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      n_errors++;
      $display("%s: no retirement record arrived within %0d cycles", tst, ret_limit);
    end
  endtask

  ////////////////////////////////////////
  // program and register window load under reset
  task automatic load_program(input string tst);
    logic [31:0] adr_q [$];
    logic [31:0] dat_q [$];
    m_mem.delete();
    m_pc = reset_pc;
    foreach (prog[i]) begin
      m_mem[i] = prog[i];
      adr_q.push_back(reset_pc + 32'(4 * i));
      dat_q.push_back(prog[i]);
    end
    // random register contents with x0 zero
    for (int r = 0; r < 32; r++) begin
      m_reg[r] = (r == 0) ? 32'd0 : $urandom;
      adr_q.push_back(gpr_base + 32'(4 * r));
      dat_q.push_back(m_reg[r]);
    end
    @(negedge bus);
    reset = 1'b1;
    foreach (adr_q[i]) begin
      load_en  = 1'b1;
      load_adr = adr_q[i];
      load_dat = dat_q[i];
      @(negedge bus);
    end
    load_en = 1'b0;
    // reset stays high 8 more cycles after the load
    repeat (8) @(negedge bus);
    reset = 1'b0;
    check(tst, "halted after reset", 32'd0, 32'(halted));
  endtask

  task automatic run_program(input string tst, input int steps);
    bit ok;
    load_program(tst);
    for (int s = 0; s < steps; s++) begin
      model_step();
      wait_retire(tst, ok);
      if (!ok) begin
        return;
      end
      compare_record(tst);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  task automatic alu_test();
    prog.delete();
    prog.push_back(u_format(5'd1, 20'($urandom)));
    prog.push_back(i_format(7'b0010011, 5'd1, 5'd1, 12'($urandom)));
    prog.push_back(i_format(7'b0010011, 5'd2, 5'd0, 12'($urandom)));
    prog.push_back(r_format(3'b000, 1'b0, 5'd3, 5'd1, 5'd2));
    prog.push_back(r_format(3'b000, 1'b1, 5'd4, 5'd1, 5'd2));
    prog.push_back(r_format(3'b111, 1'b0, 5'd5, 5'd3, 5'd4));
    prog.push_back(r_format(3'b110, 1'b0, 5'd6, 5'd1, 5'd4));
    prog.push_back(r_format(3'b100, 1'b0, 5'd7, 5'd2, 5'd5));
    // preloaded random registers as operands
    prog.push_back(r_format(3'b000, 1'b0, 5'd8, 5'd9, 5'd10));
    prog.push_back(r_format(3'b000, 1'b1, 5'd11, 5'd12, 5'd13));
    prog.push_back(i_format(7'b0010011, 5'd14, 5'd15, 12'($urandom)));
    prog.push_back(j_format(5'd0, 21'd0));
    run_program("alu", 13);
  endtask

  task automatic x0_test();
    prog.delete();
    prog.push_back(i_format(7'b0010011, 5'd0, 5'd0, 12'($urandom)));
    prog.push_back(u_format(5'd0, 20'($urandom)));
    prog.push_back(r_format(3'b000, 1'b0, 5'd0, 5'd1, 5'd2));
    // jal with x0 link skips one word
    prog.push_back(j_format(5'd0, 21'd8));
    prog.push_back(i_format(7'b0010011, 5'd5, 5'd0, 12'd1));
    prog.push_back(r_format(3'b000, 1'b0, 5'd3, 5'd0, 5'd0));
    prog.push_back(r_format(3'b110, 1'b0, 5'd4, 5'd0, 5'd7));
    prog.push_back(i_format(7'b0010011, 5'd6, 5'd0, 12'd0));
    prog.push_back(j_format(5'd0, 21'd0));
    run_program("x0", 9);
  endtask

  task automatic mem_test();
    logic [11:0] a1;
    logic [11:0] a2;
    // word addresses clear of program and register window
    a1 = 12'((256 + $urandom % 200) * 4);
    a2 = 12'((256 + $urandom % 200) * 4);
    prog.delete();
    prog.push_back(i_format(7'b0010011, 5'd1, 5'd0, a1));
    prog.push_back(u_format(5'd2, 20'($urandom)));
    prog.push_back(i_format(7'b0010011, 5'd2, 5'd2, 12'($urandom)));
    prog.push_back(s_format(5'd2, 5'd1, 12'd0));
    prog.push_back(i_format(7'b0000011, 5'd3, 5'd1, 12'd0));
    // negative offset store and load
    prog.push_back(i_format(7'b0010011, 5'd4, 5'd0, a2 + 12'd8));
    prog.push_back(s_format(5'd9, 5'd4, -12'sd8));
    prog.push_back(i_format(7'b0000011, 5'd10, 5'd4, -12'sd8));
    prog.push_back(r_format(3'b100, 1'b0, 5'd11, 5'd3, 5'd10));
    prog.push_back(i_format(7'b0000011, 5'd12, 5'd1, 12'd0));
    prog.push_back(j_format(5'd0, 21'd0));
    run_program("mem", 11);
  endtask

  task automatic branch_test();
    logic [11:0] v;
    v = 12'($urandom);
    prog.delete();
    prog.push_back(i_format(7'b0010011, 5'd1, 5'd0, v));
    prog.push_back(i_format(7'b0010011, 5'd2, 5'd0, v));
    prog.push_back(b_format(3'b000, 5'd1, 5'd2, 13'd8));
    prog.push_back(i_format(7'b0010011, 5'd3, 5'd0, 12'd1));
    prog.push_back(b_format(3'b001, 5'd1, 5'd2, 13'd8));
    // x4 differs from x1 by construction
    prog.push_back(i_format(7'b0010011, 5'd4, 5'd1, 12'd2));
    prog.push_back(j_format(5'd5, 21'd8));
    prog.push_back(i_format(7'b0010011, 5'd6, 5'd0, 12'd3));
    prog.push_back(b_format(3'b001, 5'd1, 5'd4, 13'd8));
    prog.push_back(i_format(7'b0010011, 5'd7, 5'd0, 12'd7));
    prog.push_back(b_format(3'b000, 5'd1, 5'd4, 13'd8));
    prog.push_back(j_format(5'd0, 21'd0));
    run_program("branch", 10);
  endtask

  // load beyond the RAM halts the core
  task automatic error_test();
    bit ok;
    int extra;
    extra = 0;
    prog.delete();
    prog.push_back(u_format(5'd5, 20'(mem_words * 4 / 4096)));
    prog.push_back(i_format(7'b0000011, 5'd6, 5'd5, 12'd0));
    load_program("error");
    model_step();
    wait_retire("error", ok);
    if (ok) begin
      compare_record("error");
    end
    for (int n = 0; n < ret_limit && !halted; n++) begin
      @(negedge bus);
      if (ret_vld) begin
        extra++;
      end
    end
    if (!halted) begin
      n_errors++;
      $display("error: halted did not rise after the out-of-range load");
    end
    repeat (30) begin
      @(negedge bus);
      if (ret_vld) begin
        extra++;
      end
    end
    if (extra != 0) begin
      n_errors++;
      $display("error: %0d retirement records followed the faulting load", extra);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  initial begin
    bus      = 1'b0;
    reset    = 1'b1;
    load_en  = 1'b0;
    load_adr = '0;
    load_dat = '0;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(69));
    alu_test();
    x0_test();
    mem_test();
    branch_test();
    error_test();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
